// File: vlog.f
hw/cache_pkg.sv
hw/l2_array.sv
hw/l2_data_array.sv
hw/l2_cache_datapath.sv
hw/l2_cache_control.sv
hw/l2_cache.sv
sim/l2_cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the L2 cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module l2_cache_tb \
    -f vlog.f \
    -o l2_cache_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/l2_cache_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
    exit 0
fi
exit 1

// File: sim/l2_cache_tb.sv
/* L2 cache testbench */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_LATENCY  = 6;
    localparam int NUM_RANDOM   = 300;
    localparam int NUM_REQUESTS = NUM_RANDOM + 40;
    // write-back and fill at worst latency, plus idle and compare cycles
    localparam int MISS_CYCLES  = 2 * MAX_LATENCY + 6;
    localparam int REQ_TIMEOUT  = 4 * MISS_CYCLES;
    localparam cache_pkg::word_t SEED = 32'h1bc457ba;

    logic             clk = 1'b0;
    logic             rst_n_i;
    logic             mem_read_i;
    logic             mem_write_i;
    cache_pkg::word_t mem_address_i;
    cache_pkg::mask_t mem_byte_enable_i;
    cache_pkg::line_t mem_wdata_i;
    cache_pkg::line_t mem_rdata_o;
    logic             mem_resp_o;
    logic             pmem_read_o;
    logic             pmem_write_o;
    cache_pkg::word_t pmem_address_o;
    cache_pkg::line_t pmem_wdata_o;
    cache_pkg::line_t pmem_rdata_i;
    logic             pmem_resp_i;

    // reference model state
    cache_pkg::line_t golden [cache_pkg::word_t];
    cache_pkg::tag_t  m_tag [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic             m_valid [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    logic             m_dirty [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    cache_pkg::lru_t  m_lru [cache_pkg::NUM_SETS];
    cache_pkg::word_t wb_addr_q [$];
    cache_pkg::line_t wb_data_q [$];
    logic             exp_miss;
    logic             exp_read;
    cache_pkg::line_t exp_rdata;

    // backing store seen by the downstream side
    cache_pkg::line_t pmem [cache_pkg::word_t];

    cache_pkg::word_t stim_state = SEED;
    cache_pkg::word_t lat_state  = SEED ^ 32'h5bd1e995;
    int               main_errors = 0;
    int               cmp_errors  = 0;
    int               fill_count  = 0;
    int               wb_count    = 0;
    int               tests       = 0;
    int               requests    = 0;

    l2_cache i_dut (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .mem_address_i     (mem_address_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_rdata_o       (mem_rdata_o),
        .mem_resp_o        (mem_resp_o),
        .pmem_read_o       (pmem_read_o),
        .pmem_write_o      (pmem_write_o),
        .pmem_address_o    (pmem_address_o),
        .pmem_wdata_o      (pmem_wdata_o),
        .pmem_rdata_i      (pmem_rdata_i),
        .pmem_resp_i       (pmem_resp_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic cache_pkg::word_t xorshift(input cache_pkg::word_t s);
        cache_pkg::word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cache_pkg::word_t stim_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    function automatic cache_pkg::line_t rand_line();
        cache_pkg::line_t line;
        for (int i = 0; i < 8; i++) begin
            line[32*i +: 32] = stim_rand();
        end
        return line;
    endfunction

    // contents of a line never written
    function automatic cache_pkg::line_t line_hash(input cache_pkg::word_t addr);
        cache_pkg::line_t line;
        for (int i = 0; i < 8; i++) begin
            line[32*i +: 32] = xorshift(addr ^ (32'h9e3779b9 * 32'(i + 1)));
        end
        return line;
    endfunction

    function automatic cache_pkg::line_t golden_line(input cache_pkg::word_t la);
        if (golden.exists(la)) begin
            return golden[la];
        end
        return line_hash(la);
    endfunction

    function automatic cache_pkg::word_t make_addr(input int tag, input int set, input int offset);
        return {cache_pkg::tag_t'(tag), cache_pkg::index_t'(set), 5'(offset)};
    endfunction

    function automatic int total_errors();
        return main_errors + cmp_errors;
    endfunction

    // expected read line; also queues the write-back a miss must cause
    function automatic cache_pkg::line_t predict_access(input cache_pkg::word_t addr,
            input logic wr, input cache_pkg::mask_t be, input cache_pkg::line_t wdata);
        cache_pkg::index_t set;
        cache_pkg::tag_t   tag;
        cache_pkg::word_t  la;
        cache_pkg::word_t  victim_la;
        cache_pkg::line_t  line;
        int                way;
        logic              half;
        set = addr[cache_pkg::S_OFFSET +: cache_pkg::S_INDEX];
        tag = addr[31 -: cache_pkg::S_TAG];
        la  = {addr[31:cache_pkg::S_OFFSET], {cache_pkg::S_OFFSET{1'b0}}};
        way = -1;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                way = w;
            end
        end
        exp_miss = (way < 0);
        if (exp_miss) begin
            // bit 0 picks the half, bit 1 or 2 the way inside it
            half = m_lru[set][0];
            way  = half ? 2 + int'(m_lru[set][2]) : int'(m_lru[set][1]);
            for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
                if (!m_valid[set][w]) begin
                    way = w;
                end
            end
            if (m_valid[set][way] && m_dirty[set][way]) begin
                victim_la = {m_tag[set][way], set, {cache_pkg::S_OFFSET{1'b0}}};
                wb_addr_q.push_back(victim_la);
                wb_data_q.push_back(golden_line(victim_la));
            end
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
        end
        // point the tree at the other half and at the sibling way
        half          = (way >= 2);
        m_lru[set][0] = !half;
        if (half) begin
            m_lru[set][2] = (way == 2);
        end else begin
            m_lru[set][1] = (way == 0);
        end
        line = golden_line(la);
        if (wr) begin
            for (int b = 0; b < cache_pkg::S_MASK; b++) begin
                if (be[b]) begin
                    line[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            golden[la]        = line;
            m_dirty[set][way] = 1'b1;
        end
        return line;
    endfunction

    // one request, held until mem_resp_o
    task automatic access(input cache_pkg::word_t addr, input logic wr,
            input cache_pkg::mask_t be, input cache_pkg::line_t wdata);
        int fills;
        int cycles;
        fills             = fill_count;
        exp_rdata         = predict_access(addr, wr, be, wdata);
        exp_read          = !wr;
        mem_address_i     = addr;
        mem_byte_enable_i = be;
        mem_wdata_i       = wdata;
        mem_read_i        = !wr;
        mem_write_i       = wr;
        cycles            = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!mem_resp_o && cycles < REQ_TIMEOUT);
        assert (mem_resp_o) else begin
            $display("no response to the request at %h by %0t", addr, $time);
            main_errors++;
        end
        @(negedge clk);
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
        requests++;
        assert (fill_count - fills == (exp_miss ? 1 : 0)) else begin
            $display("[FAIL] %0t pmem_read_o fills for %h expected %0d got %0d",
                     $time, addr, exp_miss ? 1 : 0, fill_count - fills);
            main_errors++;
        end
        assert (wb_count == wb_addr_q.size()) else begin
            $display("[FAIL] %0t pmem_write_o transfers after %h expected %0d got %0d",
                     $time, addr, wb_addr_q.size(), wb_count);
            main_errors++;
        end
    endtask

    task automatic write_random(input cache_pkg::word_t addr);
        cache_pkg::mask_t be;
        cache_pkg::line_t data;
        be   = stim_rand();
        data = rand_line();
        access(addr, 1'b1, be, data);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (total_errors() == errors_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests, name,
                     total_errors() - errors_before);
        end
    endtask

    initial begin : memory_model
        int delay;
        pmem_resp_i  = 1'b0;
        pmem_rdata_i = '0;
        forever begin
            @(negedge clk);
            pmem_resp_i = 1'b0;
            if (rst_n_i && (pmem_read_o || pmem_write_o)) begin
                lat_state = xorshift(lat_state);
                delay     = 1 + int'(lat_state % 32'(MAX_LATENCY));
                repeat (delay - 1) @(negedge clk);
                if (pmem_write_o) begin
                    pmem[pmem_address_o] = pmem_wdata_o;
                end else if (pmem.exists(pmem_address_o)) begin
                    pmem_rdata_i = pmem[pmem_address_o];
                end else begin
                    pmem_rdata_i = line_hash(pmem_address_o);
                end
                pmem_resp_i = 1'b1;
            end
        end
    end

    // compare read responses and write-back transfers
    always @(posedge clk) begin
        if (rst_n_i && mem_resp_o && exp_read) begin
            assert (mem_rdata_o == exp_rdata) else begin
                $display("[FAIL] %0t mem_rdata_o expected %h got %h",
                         $time, exp_rdata, mem_rdata_o);
                cmp_errors++;
            end
        end
        if (rst_n_i && pmem_read_o && pmem_resp_i) begin
            fill_count++;
        end
        if (rst_n_i && pmem_write_o && pmem_resp_i) begin
            assert (wb_count < wb_addr_q.size()) else begin
                $display("write-back to %h at %0t was not expected", pmem_address_o, $time);
                cmp_errors++;
            end
            if (wb_count < wb_addr_q.size()) begin
                assert (pmem_address_o == wb_addr_q[wb_count]) else begin
                    $display("[FAIL] %0t pmem_address_o expected %h got %h",
                             $time, wb_addr_q[wb_count], pmem_address_o);
                    cmp_errors++;
                end
                assert (pmem_wdata_o == wb_data_q[wb_count]) else begin
                    $display("[FAIL] %0t pmem_wdata_o expected %h got %h",
                             $time, wb_data_q[wb_count], pmem_wdata_o);
                    cmp_errors++;
                end
            end
            wb_count++;
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + NUM_REQUESTS * MISS_CYCLES + 50));
        $display("watchdog expired at %0t, the cache stopped answering", $time);
        $display("Errors found");
        $finish;
    end

    initial begin : stimulus
        int               errors_before;
        int               n;
        cache_pkg::word_t a;
        cache_pkg::word_t r;
        rst_n_i           = 1'b0;
        mem_read_i        = 1'b0;
        mem_write_i       = 1'b0;
        mem_address_i     = '0;
        mem_byte_enable_i = '0;
        mem_wdata_i       = '0;
        exp_read          = 1'b0;
        exp_rdata         = '0;
        for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
            m_lru[s] = '0;
            for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        errors_before = total_errors();
        assert (!mem_resp_o && !pmem_read_o && !pmem_write_o) else begin
            $display("response or memory request active after reset at %0t", $time);
            main_errors++;
        end
        a = make_addr(16, 1, 4);
        access(a, 1'b0, '0, '0);
        report_test("read miss after reset", errors_before);

        errors_before = total_errors();
        access(a, 1'b0, '0, '0);
        report_test("read hit", errors_before);

        errors_before = total_errors();
        write_random(a);
        access(a, 1'b0, '0, '0);
        write_random(make_addr(17, 1, 0));
        access(make_addr(17, 1, 8), 1'b0, '0, '0);
        report_test("masked writes", errors_before);

        // four dirty lines in set 2, then a fifth tag
        errors_before = total_errors();
        n = wb_count;
        for (int t = 0; t < 5; t++) begin
            if (t < 4) begin
                write_random(make_addr(32 + t, 2, 0));
            end else begin
                access(make_addr(32 + t, 2, 0), 1'b0, '0, '0);
            end
        end
        assert (wb_count == n + 1) else begin
            $display("[FAIL] %0t pmem_write_o dirty evictions expected %0d got %0d",
                     $time, 1, wb_count - n);
            main_errors++;
        end
        n = wb_count;
        for (int t = 0; t < 5; t++) begin
            access(make_addr(48 + t, 3, 0), 1'b0, '0, '0);
        end
        assert (wb_count == n) else begin
            $display("[FAIL] %0t pmem_write_o clean evictions expected %0d got %0d",
                     $time, 0, wb_count - n);
            main_errors++;
        end
        report_test("dirty and clean eviction", errors_before);

        // fill set 5, touch ways 1, 3, 0, then evict and re-read
        errors_before = total_errors();
        for (int t = 0; t < 4; t++) begin
            write_random(make_addr(64 + t, 5, 0));
        end
        access(make_addr(65, 5, 0), 1'b0, '0, '0);
        access(make_addr(67, 5, 0), 1'b0, '0, '0);
        access(make_addr(64, 5, 0), 1'b0, '0, '0);
        access(make_addr(68, 5, 0), 1'b0, '0, '0);
        for (int t = 0; t < 4; t++) begin
            access(make_addr(64 + t, 5, 0), 1'b0, '0, '0);
        end
        report_test("pseudo-LRU order", errors_before);

        errors_before = total_errors();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = stim_rand();
            a = make_addr(int'(r[7:0]) % 6 + 96, int'(r[10:8]), int'(r[15:11]));
            if (r[16]) begin
                write_random(a);
            end else begin
                access(a, 1'b0, '0, '0);
            end
        end
        report_test("random traffic", errors_before);

        $display("tests %0d, requests %0d, write-backs %0d, errors %0d",
                 tests, requests, wb_count, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/l2_cache.sv
/* L2 cache top level */
`timescale 1ns/1ps
`default_nettype none

module l2_cache (
    input  logic             clk,
    input  logic             rst_n_i,
    // upstream
    input  logic             mem_read_i,
    input  logic             mem_write_i,
    input  cache_pkg::word_t mem_address_i,
    input  cache_pkg::mask_t mem_byte_enable_i,
    input  cache_pkg::line_t mem_wdata_i,
    output cache_pkg::line_t mem_rdata_o,
    output logic             mem_resp_o,
    // downstream
    output logic             pmem_read_o,
    output logic             pmem_write_o,
    output cache_pkg::word_t pmem_address_o,
    output cache_pkg::line_t pmem_wdata_o,
    input  cache_pkg::line_t pmem_rdata_i,
    input  logic             pmem_resp_i
);

    cache_pkg::dimux_sel_t                           dimux_sel;
    cache_pkg::domux_sel_t                           domux_sel;
    cache_pkg::addrmux_sel_t                         addrmux_sel;
    cache_pkg::wemux_sel_t [cache_pkg::NUM_WAYS-1:0] wemux_sel;
    logic [cache_pkg::NUM_WAYS-1:0]                  valid_load;
    logic [cache_pkg::NUM_WAYS-1:0]                  dirty_load;
    logic [cache_pkg::NUM_WAYS-1:0]                  tag_load;
    logic [cache_pkg::NUM_WAYS-1:0]                  valid_in;
    logic [cache_pkg::NUM_WAYS-1:0]                  dirty_in;
    logic [cache_pkg::NUM_WAYS-1:0]                  hit;
    logic [cache_pkg::NUM_WAYS-1:0]                  valid;
    logic [cache_pkg::NUM_WAYS-1:0]                  dirty;
    cache_pkg::lru_t                                 lru;

    l2_cache_control i_control (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .hit_i         (hit),
        .valid_i       (valid),
        .dirty_i       (dirty),
        .lru_i         (lru),
        .pmem_resp_i   (pmem_resp_i),
        .mem_resp_o    (mem_resp_o),
        .pmem_read_o   (pmem_read_o),
        .pmem_write_o  (pmem_write_o),
        .dimux_sel_o   (dimux_sel),
        .domux_sel_o   (domux_sel),
        .addrmux_sel_o (addrmux_sel),
        .wemux_sel_o   (wemux_sel),
        .valid_load_o  (valid_load),
        .dirty_load_o  (dirty_load),
        .tag_load_o    (tag_load),
        .valid_in_o    (valid_in),
        .dirty_in_o    (dirty_in)
    );

    l2_cache_datapath i_datapath (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .dimux_sel_i       (dimux_sel),
        .domux_sel_i       (domux_sel),
        .addrmux_sel_i     (addrmux_sel),
        .wemux_sel_i       (wemux_sel),
        .valid_load_i      (valid_load),
        .dirty_load_i      (dirty_load),
        .tag_load_i        (tag_load),
        .valid_in_i        (valid_in),
        .dirty_in_i        (dirty_in),
        .lru_o             (lru),
        .valid_o           (valid),
        .dirty_o           (dirty),
        .hit_o             (hit),
        .mem_address_i     (mem_address_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_rdata_o       (mem_rdata_o),
        .pmem_rdata_i      (pmem_rdata_i),
        .pmem_wdata_o      (pmem_wdata_o),
        .pmem_address_o    (pmem_address_o)
    );

endmodule

`default_nettype wire

// File: hw/l2_cache_control.sv
/* L2 cache control FSM */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_control (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic                                            mem_read_i,
    input  logic                                            mem_write_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  hit_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  valid_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  dirty_i,
    input  cache_pkg::lru_t                                 lru_i,
    input  logic                                            pmem_resp_i,
    output logic                                            mem_resp_o,
    output logic                                            pmem_read_o,
    output logic                                            pmem_write_o,
    output cache_pkg::dimux_sel_t                           dimux_sel_o,
    output cache_pkg::domux_sel_t                           domux_sel_o,
    output cache_pkg::addrmux_sel_t                         addrmux_sel_o,
    output cache_pkg::wemux_sel_t [cache_pkg::NUM_WAYS-1:0] wemux_sel_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  valid_load_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  dirty_load_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  tag_load_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  valid_in_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  dirty_in_o
);

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        FILL
    } state_t;

    state_t     state_q;
    state_t     state_d;
    logic       request;
    logic [1:0] hit_way;
    logic [1:0] lru_way;
    logic [1:0] victim;

    assign request = mem_read_i | mem_write_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        hit_way = 2'd0;
        for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
            if (hit_i[i]) begin
                hit_way = 2'(i);
            end
        end
    end

    assign lru_way = lru_i[0] ? {1'b1, lru_i[2]} : {1'b0, lru_i[1]};

    // lowest invalid way first, else the tree's choice
    always_comb begin
        victim = lru_way;
        for (int i = cache_pkg::NUM_WAYS - 1; i >= 0; i--) begin
            if (!valid_i[i]) begin
                victim = 2'(i);
            end
        end
    end

    always_comb begin
        state_d       = state_q;
        mem_resp_o    = 1'b0;
        pmem_read_o   = 1'b0;
        pmem_write_o  = 1'b0;
        dimux_sel_o   = cache_pkg::DI_CPU;
        domux_sel_o   = cache_pkg::domux_sel_t'(hit_way);
        addrmux_sel_o = cache_pkg::ADDR_CPU;
        valid_load_o  = '0;
        dirty_load_o  = '0;
        tag_load_o    = '0;
        valid_in_o    = '0;
        dirty_in_o    = '0;
        for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
            wemux_sel_o[i] = cache_pkg::WE_ZEROS;
        end

        case (state_q)
            IDLE: begin
                if (request) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                if (hit_i != '0) begin
                    mem_resp_o = 1'b1;
                    if (mem_write_i) begin
                        wemux_sel_o[hit_way]  = cache_pkg::WE_MBE;
                        dirty_load_o[hit_way] = 1'b1;
                        dirty_in_o[hit_way]   = 1'b1;
                    end
                    state_d = IDLE;
                end else if (dirty_i[victim]) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = FILL;
                end
            end
            WRITEBACK: begin
                pmem_write_o  = 1'b1;
                domux_sel_o   = cache_pkg::domux_sel_t'(victim);
                // way addresses follow ADDR_CPU in the encoding
                addrmux_sel_o = cache_pkg::addrmux_sel_t'({1'b0, victim} + 3'd1);
                if (pmem_resp_i) begin
                    dirty_load_o[victim] = 1'b1;
                    state_d              = FILL;
                end
            end
            FILL: begin
                pmem_read_o = 1'b1;
                dimux_sel_o = cache_pkg::DI_MEM;
                if (pmem_resp_i) begin
                    wemux_sel_o[victim]  = cache_pkg::WE_ONES;
                    tag_load_o[victim]   = 1'b1;
                    valid_load_o[victim] = 1'b1;
                    valid_in_o[victim]   = 1'b1;
                    dirty_load_o[victim] = 1'b1;
                    state_d              = COMPARE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/l2_cache_datapath.sv
/* L2 cache datapath */
`timescale 1ns/1ps
`default_nettype none

module l2_cache_datapath (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    // from control
    input  cache_pkg::dimux_sel_t                           dimux_sel_i,
    input  cache_pkg::domux_sel_t                           domux_sel_i,
    input  cache_pkg::addrmux_sel_t                         addrmux_sel_i,
    input  cache_pkg::wemux_sel_t [cache_pkg::NUM_WAYS-1:0] wemux_sel_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  valid_load_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  dirty_load_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  tag_load_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  valid_in_i,
    input  logic [cache_pkg::NUM_WAYS-1:0]                  dirty_in_i,
    // to control
    output cache_pkg::lru_t                                 lru_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  valid_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  dirty_o,
    output logic [cache_pkg::NUM_WAYS-1:0]                  hit_o,
    // upstream
    input  cache_pkg::word_t                                mem_address_i,
    input  logic                                            mem_read_i,
    input  logic                                            mem_write_i,
    input  cache_pkg::mask_t                                mem_byte_enable_i,
    input  cache_pkg::line_t                                mem_wdata_i,
    output cache_pkg::line_t                                mem_rdata_o,
    // downstream
    input  cache_pkg::line_t                                pmem_rdata_i,
    output cache_pkg::line_t                                pmem_wdata_o,
    output cache_pkg::word_t                                pmem_address_o
);

    localparam int TAG_LSB = cache_pkg::S_OFFSET + cache_pkg::S_INDEX;

    cache_pkg::index_t set;
    cache_pkg::tag_t   tag;
    cache_pkg::word_t  line_address;
    logic              request;

    cache_pkg::tag_t  tag_out  [cache_pkg::NUM_WAYS];
    cache_pkg::line_t data_out [cache_pkg::NUM_WAYS];
    cache_pkg::mask_t wemux_out [cache_pkg::NUM_WAYS];
    cache_pkg::line_t dimux_out;
    cache_pkg::line_t domux_out;
    cache_pkg::word_t addrmux_out;

    logic              lru_load;
    cache_pkg::index_t lru_windex;
    cache_pkg::lru_t   lru_next;
    cache_pkg::lru_t   lru_base;
    cache_pkg::lru_t   lru_upd;

    assign set          = mem_address_i[TAG_LSB-1:cache_pkg::S_OFFSET];
    assign tag          = mem_address_i[31:TAG_LSB];
    assign line_address = {mem_address_i[31:cache_pkg::S_OFFSET], {cache_pkg::S_OFFSET{1'b0}}};
    assign request      = mem_read_i | mem_write_i;

    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
        assign hit_o[w] = valid_o[w] && (tag_out[w] == tag);

        l2_data_array i_data (
            .clk        (clk),
            .write_en_i (wemux_out[w]),
            .index_i    (set),
            .data_i     (dimux_out),
            .data_o     (data_out[w])
        );

        l2_array #(.payload_t(logic)) i_valid (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .load_i   (valid_load_i[w]),
            .rindex_i (set),
            .windex_i (set),
            .data_i   (valid_in_i[w]),
            .data_o   (valid_o[w])
        );

        l2_array #(.payload_t(logic)) i_dirty (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .load_i   (dirty_load_i[w]),
            .rindex_i (set),
            .windex_i (set),
            .data_i   (dirty_in_i[w]),
            .data_o   (dirty_o[w])
        );

        l2_array #(.payload_t(cache_pkg::tag_t)) i_tag (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .load_i   (tag_load_i[w]),
            .rindex_i (set),
            .windex_i (set),
            .data_i   (tag),
            .data_o   (tag_out[w])
        );
    end

    // forward the pending update so back-to-back hits see it
    assign lru_base = (lru_load && (lru_windex == set)) ? lru_next : lru_o;

    // point the tree away from the way just hit
    always_comb begin
        lru_upd = lru_base;
        case (hit_o)
            4'b0001: begin
                lru_upd[0] = 1'b1;
                lru_upd[1] = 1'b1;
            end
            4'b0010: begin
                lru_upd[0] = 1'b1;
                lru_upd[1] = 1'b0;
            end
            4'b0100: begin
                lru_upd[0] = 1'b0;
                lru_upd[2] = 1'b1;
            end
            4'b1000: begin
                lru_upd[0] = 1'b0;
                lru_upd[2] = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lru_load <= 1'b0;
        end else begin
            lru_load <= request && (hit_o != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (request && (hit_o != '0)) begin
            lru_windex <= set;
            lru_next   <= lru_upd;
        end
    end

    l2_array #(.payload_t(cache_pkg::lru_t)) i_lru (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .load_i   (lru_load),
        .rindex_i (set),
        .windex_i (lru_windex),
        .data_i   (lru_next),
        .data_o   (lru_o)
    );

    always_comb begin
        for (int i = 0; i < cache_pkg::NUM_WAYS; i++) begin
            case (wemux_sel_i[i])
                cache_pkg::WE_ONES: wemux_out[i] = '1;
                cache_pkg::WE_MBE:  wemux_out[i] = mem_byte_enable_i;
                default:            wemux_out[i] = '0;
            endcase
        end

        case (dimux_sel_i)
            cache_pkg::DI_MEM: dimux_out = pmem_rdata_i;
            default:           dimux_out = mem_wdata_i;
        endcase

        case (domux_sel_i)
            cache_pkg::DO_WAY1: domux_out = data_out[1];
            cache_pkg::DO_WAY2: domux_out = data_out[2];
            cache_pkg::DO_WAY3: domux_out = data_out[3];
            default:            domux_out = data_out[0];
        endcase

        // stored tag rebuilds the victim's line address
        case (addrmux_sel_i)
            cache_pkg::ADDR_WAY0: addrmux_out = {tag_out[0], set, {cache_pkg::S_OFFSET{1'b0}}};
            cache_pkg::ADDR_WAY1: addrmux_out = {tag_out[1], set, {cache_pkg::S_OFFSET{1'b0}}};
            cache_pkg::ADDR_WAY2: addrmux_out = {tag_out[2], set, {cache_pkg::S_OFFSET{1'b0}}};
            cache_pkg::ADDR_WAY3: addrmux_out = {tag_out[3], set, {cache_pkg::S_OFFSET{1'b0}}};
            default:              addrmux_out = line_address;
        endcase
    end

    assign mem_rdata_o    = domux_out;
    assign pmem_wdata_o   = domux_out;
    assign pmem_address_o = addrmux_out;

endmodule

`default_nettype wire

// File: hw/l2_data_array.sv
/* Cache line storage */
`timescale 1ns/1ps
`default_nettype none

module l2_data_array (
    input  logic              clk,
    input  cache_pkg::mask_t  write_en_i,
    input  cache_pkg::index_t index_i,
    input  cache_pkg::line_t  data_i,
    output cache_pkg::line_t  data_o
);

    cache_pkg::line_t mem_q [cache_pkg::NUM_SETS];

    // one enable per byte lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < cache_pkg::S_MASK; b++) begin
            if (write_en_i[b]) begin
                mem_q[index_i][8*b +: 8] <= data_i[8*b +: 8];
            end
        end
    end

    assign data_o = mem_q[index_i];

endmodule

`default_nettype wire

// File: hw/l2_array.sv
/* Per-set register array */
`timescale 1ns/1ps
`default_nettype none

module l2_array #(
    parameter type payload_t = logic
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              load_i,
    input  cache_pkg::index_t rindex_i,
    input  cache_pkg::index_t windex_i,
    input  payload_t          data_i,
    output payload_t          data_o
);

    payload_t mem_q [cache_pkg::NUM_SETS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (load_i) begin
            mem_q[windex_i] <= data_i;
        end
    end

    // combinational read at the current set
    assign data_o = mem_q[rindex_i];

endmodule

`default_nettype wire

// File: hw/cache_pkg.sv
/* L2 cache shared definitions */
`default_nettype none

package cache_pkg;

    // geometry
    localparam int S_OFFSET = 5;
    localparam int S_INDEX  = 3;
    localparam int S_TAG    = 32 - S_OFFSET - S_INDEX;
    localparam int S_MASK   = 2 ** S_OFFSET;
    localparam int S_LINE   = 8 * S_MASK;
    localparam int NUM_SETS = 2 ** S_INDEX;
    localparam int NUM_WAYS = 4;

    typedef logic [31:0]        word_t;
    typedef logic [S_LINE-1:0]  line_t;
    typedef logic [S_MASK-1:0]  mask_t;
    typedef logic [S_TAG-1:0]   tag_t;
    typedef logic [S_INDEX-1:0] index_t;

    // tree bits point at the victim, bit 0 picks the half
    typedef logic [2:0] lru_t;

    typedef enum logic {
        DI_CPU,
        DI_MEM
    } dimux_sel_t;

    typedef enum logic [1:0] {
        DO_WAY0,
        DO_WAY1,
        DO_WAY2,
        DO_WAY3
    } domux_sel_t;

    // way encodings follow ADDR_CPU in order
    typedef enum logic [2:0] {
        ADDR_CPU,
        ADDR_WAY0,
        ADDR_WAY1,
        ADDR_WAY2,
        ADDR_WAY3
    } addrmux_sel_t;

    typedef enum logic [1:0] {
        WE_ZEROS,
        WE_ONES,
        WE_MBE
    } wemux_sel_t;

endpackage

`default_nettype wire
